// File: fetch_slice.f
+incdir+.
rv_insn_pkg.sv
fetch_pkg.sv
fetch_intf.sv
insn_predecode.sv
return_stack.sv
fetch_queue.sv
block_aligner.sv
fetch_slice.sv
tb_fetch_slice.sv

// File: Bender.yml
package:
  name: fetch_slice

sources:
  - include_dirs:
      - .
    files:
      - rv_insn_pkg.sv
      - fetch_pkg.sv
      - fetch_intf.sv
      - insn_predecode.sv
      - return_stack.sv
      - fetch_queue.sv
      - block_aligner.sv
      - fetch_slice.sv
      - target: test
        include_dirs:
          - .
        files:
          - tb_fetch_slice.sv

// File: tb_fetch_slice.sv
`timescale 1ns/10ps
`include "fetch_slice_config.svh"

module tb_fetch_slice;
    import fetch_pkg::*;
    import rv_insn_pkg::*;

    localparam int XLEN         = `FETCH_XLEN;
    localparam int BW           = 16*`FETCH_BLOCK_HW;
    localparam int NROWS        = 14;
    localparam int RESET_CYCLES = 16;
    localparam logic [31:0] SEED = 32'h4ec2_4465;

    // kind bits in struct order branch, jal, jalr, call, ret
    localparam insn_kind_t K_NONE   = 5'b00000;
    localparam insn_kind_t K_BRANCH = 5'b10000;
    localparam insn_kind_t K_JAL    = 5'b01000;
    localparam insn_kind_t K_CALL   = 5'b00110;   // c.jalr x6
    localparam insn_kind_t K_RET    = 5'b00101;   // c.jr ra

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  blk_valid;
    logic [XLEN-1:0]       blk_pc;
    logic [BW-1:0]         blk_data;
    logic                  blk_pred_taken;
    logic [XLEN-1:0]       blk_pred_target;
    logic                  flush;
    logic [1:0]            take;
    logic [1:0]            out_valid;
    logic [1:0][XLEN-1:0]  out_pc;
    logic [1:0][31:0]      out_ir;
    logic [1:0][XLEN-1:0]  out_pnpc;
    logic [1:0]            out_branch;
    logic [1:0]            out_jal;
    logic [1:0]            out_jalr;
    logic [1:0]            out_call;
    logic [1:0]            out_ret;
    logic                  redir;
    logic [XLEN-1:0]       redir_pc;

    // stimulus table with expected instructions in one flat queue
    logic [XLEN-1:0] row_pc       [NROWS];
    logic [BW-1:0]   row_data     [NROWS];
    logic            row_taken    [NROWS];
    logic [XLEN-1:0] row_target   [NROWS];
    logic            row_redir    [NROWS];
    logic [XLEN-1:0] row_redir_pc [NROWS];
    logic            row_drain    [NROWS];   // take and compare the block's insns
    logic            row_flush    [NROWS];   // flush once the block is done
    int              row_n        [NROWS];
    fetch_entry_t    exp_q [$];
    int              nrows    = 0;
    int              next_exp = 0;

    fetch_slice u_fetch_slice (
        .clk             (clk),
        .rst             (rst),
        .blk_valid       (blk_valid),
        .blk_pc          (blk_pc),
        .blk_data        (blk_data),
        .blk_pred_taken  (blk_pred_taken),
        .blk_pred_target (blk_pred_target),
        .flush           (flush),
        .take            (take),
        .out_valid       (out_valid),
        .out_pc          (out_pc),
        .out_ir          (out_ir),
        .out_pnpc        (out_pnpc),
        .out_branch      (out_branch),
        .out_jal         (out_jal),
        .out_jalr        (out_jalr),
        .out_call        (out_call),
        .out_ret         (out_ret),
        .redir           (redir),
        .redir_pc        (redir_pc)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_redir(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Error: redir_pc = %h, expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_entry(input string name, input fetch_entry_t got,
                               input fetch_entry_t exp);
        if (got !== exp) begin
            $display("Error: %s pc=%h ir=%h pnpc=%h kind=%h", name, got.pc, got.ir,
                     got.pnpc, got.kind);
            $display("  expected pc=%h ir=%h pnpc=%h kind=%h", exp.pc, exp.ir,
                     exp.pnpc, exp.kind);
            abort_run();
        end
    endtask

    function automatic fetch_entry_t lane_entry(input int l);
        fetch_entry_t e;
        e.pc   = out_pc[l];
        e.ir   = out_ir[l];
        e.pnpc = out_pnpc[l];
        e.kind = {out_branch[l], out_jal[l], out_jalr[l], out_call[l], out_ret[l]};
        return e;
    endfunction

    task automatic add_block(input logic [XLEN-1:0] pc, input logic [BW-1:0] data,
                             input logic taken, input logic [XLEN-1:0] target,
                             input logic redir_exp, input logic [XLEN-1:0] redir_to,
                             input logic drain, input logic flush_after);
        row_pc[nrows]       = pc;
        row_data[nrows]     = data;
        row_taken[nrows]    = taken;
        row_target[nrows]   = target;
        row_redir[nrows]    = redir_exp;
        row_redir_pc[nrows] = redir_to;
        row_drain[nrows]    = drain;
        row_flush[nrows]    = flush_after;
        row_n[nrows]        = 0;
        nrows++;
    endtask

    task automatic add_insn(input logic [XLEN-1:0] pc, input logic [31:0] ir,
                            input logic [XLEN-1:0] pnpc, input insn_kind_t kind);
        fetch_entry_t e;
        e.pc   = pc;
        e.ir   = ir;   // compressed slots carry the following half-word too
        e.pnpc = pnpc;
        e.kind = kind;
        exp_q.push_back(e);
        row_n[nrows-1]++;
    endtask

    task automatic build_table();
        // c.li, addi, c.nop with no prediction
        add_block(64'h8000_0000, {16'h0001, 16'h0015, 16'h0513, 16'h4505},
                  1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        add_insn(64'h8000_0000, 32'h0513_4505, 64'h8000_0002, K_NONE);
        add_insn(64'h8000_0002, 32'h0015_0513, 64'h8000_0006, K_NONE);
        add_insn(64'h8000_0006, 32'h0000_0001, 64'h8000_0008, K_NONE);
        // 32-bit insn cut off at the last half-word
        add_block(64'h8000_0100, {16'h0513, 16'h0001, 16'h4505, 16'h0001},
                  1'b0, '0, 1'b1, 64'h8000_0106, 1'b1, 1'b0);
        add_insn(64'h8000_0100, 32'h4505_0001, 64'h8000_0102, K_NONE);
        add_insn(64'h8000_0102, 32'h0001_4505, 64'h8000_0104, K_NONE);
        add_insn(64'h8000_0104, 32'h0513_0001, 64'h8000_0106, K_NONE);
        // jal x0, +0x40 predicted not-taken
        add_block(64'h8000_0200, {16'h0001, 16'h0400, 16'h006F, 16'h0001},
                  1'b0, '0, 1'b1, 64'h8000_0242, 1'b1, 1'b0);
        add_insn(64'h8000_0200, 32'h006F_0001, 64'h8000_0202, K_NONE);
        add_insn(64'h8000_0202, 32'h0400_006F, 64'h8000_0242, K_JAL);
        // c.j +8 in slot 0
        add_block(64'h8000_0300, {16'h0001, 16'h0001, 16'h0001, 16'hA021},
                  1'b0, '0, 1'b1, 64'h8000_0308, 1'b1, 1'b0);
        add_insn(64'h8000_0300, 32'h0001_A021, 64'h8000_0308, K_JAL);
        // taken predicted on a plain insn
        add_block(64'h8000_0400, {16'h0001, 16'h4505, 16'h0015, 16'h0513},
                  1'b1, 64'h8000_1000, 1'b1, 64'h8000_0408, 1'b1, 1'b0);
        add_insn(64'h8000_0400, 32'h0015_0513, 64'h8000_0404, K_NONE);
        add_insn(64'h8000_0404, 32'h0001_4505, 64'h8000_0406, K_NONE);
        add_insn(64'h8000_0406, 32'h0000_0001, 64'h8000_0408, K_NONE);
        // call pushes 0x...504 and the ret in the next block returns there
        add_block(64'h8000_0500, {16'h0001, 16'h0001, 16'h9302, 16'h0001},
                  1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        add_insn(64'h8000_0500, 32'h9302_0001, 64'h8000_0502, K_NONE);
        add_insn(64'h8000_0502, 32'h0001_9302, 64'h8000_0504, K_CALL);
        add_insn(64'h8000_0504, 32'h0001_0001, 64'h8000_0506, K_NONE);
        add_insn(64'h8000_0506, 32'h0000_0001, 64'h8000_0508, K_NONE);
        add_block(64'h8000_0600, {16'h8082, 16'h0001, 16'h0001, 16'h0001},
                  1'b1, 64'h8000_0700, 1'b1, 64'h8000_0504, 1'b1, 1'b0);
        add_insn(64'h8000_0600, 32'h0001_0001, 64'h8000_0602, K_NONE);
        add_insn(64'h8000_0602, 32'h0001_0001, 64'h8000_0604, K_NONE);
        add_insn(64'h8000_0604, 32'h8082_0001, 64'h8000_0606, K_NONE);
        add_insn(64'h8000_0606, 32'h0000_8082, 64'h8000_0504, K_RET);
        // fill the queue to 15 without take and overflow by three
        add_block(64'h8000_0800, {16'h0001, 16'h0001, 16'h0015, 16'h0513},
                  1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
        add_block(64'h8000_0810, {4{16'h0001}}, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
        add_block(64'h8000_0820, {4{16'h0001}}, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
        add_block(64'h8000_0830, {4{16'h0001}}, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
        add_block(64'h8000_0840, {4{16'h0001}}, 1'b0, '0, 1'b1, 64'h8000_0842,
                  1'b0, 1'b1);
        // normal flow again after the flush
        add_block(64'h8000_0A00, {16'h0001, 16'h0015, 16'h0513, 16'h4505},
                  1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        add_insn(64'h8000_0A00, 32'h0513_4505, 64'h8000_0A02, K_NONE);
        add_insn(64'h8000_0A02, 32'h0015_0513, 64'h8000_0A06, K_NONE);
        add_insn(64'h8000_0A06, 32'h0000_0001, 64'h8000_0A08, K_NONE);
        // beq x0, x0, +0x100 ending the block, predicted taken to the right target
        add_block(64'h8000_0B00, {16'h1000, 16'h0063, 16'h0001, 16'h0001},
                  1'b1, 64'h8000_0C04, 1'b0, '0, 1'b1, 1'b0);
        add_insn(64'h8000_0B00, 32'h0001_0001, 64'h8000_0B02, K_NONE);
        add_insn(64'h8000_0B02, 32'h0063_0001, 64'h8000_0B04, K_NONE);
        add_insn(64'h8000_0B04, 32'h1000_0063, 64'h8000_0C04, K_BRANCH);
    endtask

    task automatic run_row(input int r);
        logic seen;
        int   idx;
        int   left;
        int   n;
        repeat ($urandom % 4) @(posedge clk);   // idle gap
        @(posedge clk);
        blk_valid       <= 1'b1;
        blk_pc          <= row_pc[r];
        blk_data        <= row_data[r];
        blk_pred_taken  <= row_taken[r];
        blk_pred_target <= row_target[r];
        @(posedge clk);
        blk_valid <= 1'b0;
        seen = 1'b0;
        for (int k = 0; k < 2 && !seen; k++) begin
            @(negedge clk);
            seen = redir;
        end
        check_flag("redir", seen, row_redir[r]);
        if (row_redir[r]) check_redir(redir_pc, row_redir_pc[r]);
        @(negedge clk);
        check_flag("redir", redir, 1'b0);   // single-cycle pulse
        if (row_drain[r]) begin
            idx  = next_exp;
            left = row_n[r];
            while (left > 0) begin
                check_flag("out_valid[0]", out_valid[0], 1'b1);
                check_flag("out_valid[1]", out_valid[1], left > 1);
                check_entry("out lane 0", lane_entry(0), exp_q[idx]);
                if (left > 1) check_entry("out lane 1", lane_entry(1), exp_q[idx+1]);
                n = (left > 1 && $urandom % 2 == 1) ? 2 : 1;
                @(posedge clk);
                take <= (n == 2) ? 2'b11 : 2'b01;
                @(posedge clk);
                take <= 2'b00;
                @(negedge clk);
                idx  += n;
                left -= n;
            end
            check_flag("out_valid[0]", out_valid[0], 1'b0);   // no slot past the last one
            next_exp = idx;
        end
        if (row_flush[r]) begin
            check_flag("out_valid[1]", out_valid[1], 1'b1);   // queue still full
            @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
            @(negedge clk);
            check_flag("out_valid[0]", out_valid[0], 1'b0);
            check_flag("out_valid[1]", out_valid[1], 1'b0);
        end
    endtask

    initial begin
        rst             = 1'b1;
        blk_valid       = 1'b0;
        blk_pc          = '0;
        blk_data        = '0;
        blk_pred_taken  = 1'b0;
        blk_pred_target = '0;
        flush           = 1'b0;
        take            = 2'b00;
        void'($urandom(SEED));
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_flag("out_valid[0]", out_valid[0], 1'b0);
            check_flag("out_valid[1]", out_valid[1], 1'b0);
            check_flag("redir", redir, 1'b0);
        end
        for (int r = 0; r < nrows; r++) run_row(r);
        $display("Test OK");
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        repeat (RESET_CYCLES + 40*NROWS) @(posedge clk);
        $display("timeout: the run stalled before every block was checked");
        abort_run();
    end

endmodule

// File: fetch_slice.sv
`timescale 1ns/10ps
`include "fetch_slice_config.svh"

module fetch_slice (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           blk_valid,
    input  logic [`FETCH_XLEN-1:0]                         blk_pc,
    input  logic [16*`FETCH_BLOCK_HW-1:0]                  blk_data,
    input  logic                                           blk_pred_taken,
    input  logic [`FETCH_XLEN-1:0]                         blk_pred_target,
    input  logic                                           flush,
    input  logic [`FETCH_DEQ_WIDTH-1:0]                    take,
    output logic [`FETCH_DEQ_WIDTH-1:0]                    out_valid,
    output logic [`FETCH_DEQ_WIDTH-1:0][`FETCH_XLEN-1:0]   out_pc,
    output logic [`FETCH_DEQ_WIDTH-1:0][31:0]              out_ir,
    output logic [`FETCH_DEQ_WIDTH-1:0][`FETCH_XLEN-1:0]   out_pnpc,
    output logic [`FETCH_DEQ_WIDTH-1:0]                    out_branch,
    output logic [`FETCH_DEQ_WIDTH-1:0]                    out_jal,
    output logic [`FETCH_DEQ_WIDTH-1:0]                    out_jalr,
    output logic [`FETCH_DEQ_WIDTH-1:0]                    out_call,
    output logic [`FETCH_DEQ_WIDTH-1:0]                    out_ret,
    output logic                                           redir,
    output logic [`FETCH_XLEN-1:0]                         redir_pc
);
    import fetch_pkg::*;

    localparam int DEQ = `FETCH_DEQ_WIDTH;

    block_pred_t                 blk_pred;
    fetch_entry_t [DEQ-1:0]      head;
    logic         [DEQ-1:0]      head_valid;

    fq_enq_if u_enq_if ();
    ras_if    u_ras_if ();

    assign blk_pred = '{taken: blk_pred_taken, target: blk_pred_target};

    block_aligner u_block_aligner (
        .clk       (clk),
        .rst       (rst),
        .blk_valid (blk_valid),
        .blk_pc    (blk_pc),
        .blk_data  (blk_data),
        .blk_pred  (blk_pred),
        .flush     (flush),
        .redir     (redir),
        .redir_pc  (redir_pc),
        .enq       (u_enq_if),
        .ras       (u_ras_if)
    );

    return_stack u_return_stack (
        .clk (clk),
        .rst (rst),
        .ras (u_ras_if)
    );

    fetch_queue u_fetch_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .take       (take),
        .enq        (u_enq_if),
        .head       (head),
        .head_valid (head_valid)
    );

    // per-lane fields of the queue head
    always_comb begin
        for (int i = 0; i < DEQ; i++) begin
            out_pc[i]     = head[i].pc;
            out_ir[i]     = head[i].ir;
            out_pnpc[i]   = head[i].pnpc;
            out_branch[i] = head[i].kind.branch;
            out_jal[i]    = head[i].kind.jal;
            out_jalr[i]   = head[i].kind.jalr;
            out_call[i]   = head[i].kind.call;
            out_ret[i]    = head[i].kind.ret;
        end
    end

    assign out_valid = head_valid;

endmodule

// File: block_aligner.sv
`timescale 1ns/10ps
`include "fetch_slice_config.svh"

module block_aligner (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          blk_valid,
    input  logic [`FETCH_XLEN-1:0]        blk_pc,
    input  logic [16*`FETCH_BLOCK_HW-1:0] blk_data,
    input  fetch_pkg::block_pred_t        blk_pred,
    input  logic                          flush,
    output logic                          redir,
    output logic [`FETCH_XLEN-1:0]        redir_pc,
    fq_enq_if.source                      enq,
    ras_if.client                         ras
);
    import fetch_pkg::*;
    import rv_insn_pkg::*;

    localparam int XLEN = `FETCH_XLEN;
    localparam int HW   = `FETCH_BLOCK_HW;
    localparam int PW   = $clog2(2*HW+1);   // slot position in half-words

    logic                    b_valid;
    logic [XLEN-1:0]         b_pc;
    logic [16*HW-1:0]        b_data;
    block_pred_t             b_pred;
    logic                    active;
    logic [16*HW+15:0]       b_ext;         // zero half-word past the end
    logic [PW-1:0]           pos [HW+1];
    logic [HW-1:0]           present;
    logic [HW-1:0]           ends;          // insn ends on the last half-word
    logic [HW-1:0]           cut;           // 32-bit insn starting on the last half-word
    logic [HW-1:0][XLEN-1:0] slot_pc;
    logic [HW-1:0][XLEN-1:0] target;
    logic [HW-1:0][XLEN-1:0] fall;
    insn_u      [HW-1:0]     slot_ir;
    insn_kind_t [HW-1:0]     kind;
    fetch_entry_t [HW-1:0]   entry;
    logic [$clog2(HW+1)-1:0] n_enq;
    logic                    redir_d;
    logic [XLEN-1:0]         npc_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid <= 1'b0;
            redir   <= 1'b0;
        end else begin
            // younger blocks are wrong path once a redirect is decided
            b_valid <= blk_valid & ~redir & ~redir_d & ~flush;
            redir   <= redir_d;
        end
        if (blk_valid) begin
            b_pc   <= blk_pc;
            b_data <= blk_data;
            b_pred <= blk_pred;
        end
        if (redir_d) redir_pc <= npc_d;
    end

    assign active = b_valid & ~flush;
    assign b_ext  = {16'h0, b_data};

    always_comb begin
        pos[0] = '0;
        for (int i = 0; i < HW; i++) begin
            present[i] = pos[i] < PW'(HW);
            slot_ir[i] = present[i] ? b_ext[16*pos[i] +: 32] : '0;
            slot_pc[i] = b_pc + XLEN'({pos[i], 1'b0});
            pos[i+1]   = pos[i] + ((slot_ir[i].c.quadrant != Q_FULL) ? PW'(1) : PW'(2));
            ends[i]    = pos[i+1] == PW'(HW);
            cut[i]     = present[i] && pos[i+1] > PW'(HW);
        end
    end

    for (genvar i = 0; i < HW; i++) begin : g_pd
        insn_predecode u_predecode (
            .pc          (slot_pc[i]),
            .ir          (slot_ir[i]),
            .ras_top     (ras.top),     // start-of-cycle top for every slot
            .kind        (kind[i]),
            .target      (target[i]),
            .fallthrough (fall[i])
        );
    end

    // walk slots in order, first redirect event stops the block
    always_comb begin
        logic pred_taken;
        logic bad;
        logic stop;
        n_enq         = '0;
        redir_d       = 1'b0;
        npc_d         = '0;
        stop          = 1'b0;
        ras.push      = 1'b0;
        ras.pop       = 1'b0;
        ras.push_addr = '0;
        for (int i = 0; i < HW; i++) begin
            pred_taken    = ends[i] & b_pred.taken;
            bad           = 1'b0;
            entry[i].pc   = slot_pc[i];
            entry[i].ir   = slot_ir[i];
            entry[i].kind = kind[i];
            entry[i].pnpc = pred_taken ? b_pred.target : fall[i];
            if (active && !stop && present[i]) begin
                if (cut[i] || n_enq >= enq.free) begin   // refetch from here
                    redir_d = 1'b1;
                    npc_d   = slot_pc[i];
                    stop    = 1'b1;
                end else begin
                    n_enq = n_enq + 1'b1;
                    if (kind[i].call) begin
                        ras.push      = 1'b1;
                        ras.push_addr = fall[i];
                    end
                    if (kind[i].ret) ras.pop = 1'b1;
                    if (!(kind[i].branch | kind[i].jal | kind[i].jalr) && pred_taken) begin
                        bad           = 1'b1;   // taken on a plain insn
                        entry[i].pnpc = fall[i];
                    end else if ((kind[i].jal | (kind[i].branch & pred_taken) |
                                  (kind[i].ret & ras.nonempty)) &&
                                 (!pred_taken || target[i] != b_pred.target)) begin
                        bad           = 1'b1;
                        entry[i].pnpc = target[i];
                    end
                    if (bad) begin
                        redir_d = 1'b1;
                        npc_d   = entry[i].pnpc;
                        stop    = 1'b1;
                    end
                end
            end
        end
    end

    assign enq.count = n_enq;
    assign enq.slot  = entry;

endmodule

// File: fetch_queue.sv
`timescale 1ns/10ps
`include "fetch_slice_config.svh"

module fetch_queue (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          flush,
    input  logic [`FETCH_DEQ_WIDTH-1:0]                   take,
    fq_enq_if.sink                                        enq,
    output fetch_pkg::fetch_entry_t [`FETCH_DEQ_WIDTH-1:0] head,
    output logic [`FETCH_DEQ_WIDTH-1:0]                   head_valid
);
    import fetch_pkg::*;

    localparam int D  = `FETCH_FQ_DEPTH;
    localparam int AW = $clog2(D);
    localparam int NW = AW + 1;
    localparam int R  = `FETCH_DEQ_WIDTH;
    localparam int W  = `FETCH_BLOCK_HW;

    fetch_entry_t  mem [D];
    logic [AW-1:0] front;
    logic [NW-1:0] num;
    logic [NW-1:0] n_out;

    always_comb begin
        n_out = '0;
        for (int i = 0; i < R; i++) begin
            head[i]       = mem[AW'(front + i)];
            head_valid[i] = i < num;
            if (take[i] && head_valid[i]) n_out = n_out + 1'b1;
        end
    end

    assign enq.free = NW'(D) - num;   // dequeues this cycle not counted

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            front <= '0;
            num   <= '0;
        end else begin
            front <= front + AW'(n_out);
            num   <= num + NW'(enq.count) - n_out;
        end
    end

    // first count slots land after the tail
    always_ff @(posedge clk) begin
        for (int i = 0; i < W; i++) begin
            if (i < enq.count) mem[AW'(front + num + i)] <= enq.slot[i];
        end
    end

endmodule

// File: return_stack.sv
`timescale 1ns/10ps
`include "fetch_slice_config.svh"

module return_stack (
    input logic   clk,
    input logic   rst,
    ras_if.stack  ras
);
    localparam int XLEN = `FETCH_XLEN;
    localparam int D    = `FETCH_RAS_DEPTH;
    localparam int AW   = $clog2(D);

    logic [XLEN-1:0] mem [D];
    logic [AW-1:0]   ptr;   // next free slot, wraps
    logic [AW:0]     cnt;   // saturates at depth

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
            cnt <= '0;
        end else if (ras.push && ras.pop) begin
            if (cnt == '0) cnt <= (AW+1)'(1);   // replace on empty acts as push
        end else if (ras.push) begin
            ptr <= ptr + 1'b1;
            if (cnt != (AW+1)'(D)) cnt <= cnt + 1'b1;   // full: oldest is overwritten
        end else if (ras.pop && cnt != '0) begin
            ptr <= ptr - 1'b1;
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ras.push) mem[ras.pop ? ptr - 1'b1 : ptr] <= ras.push_addr;
    end

    assign ras.top      = mem[ptr - 1'b1];
    assign ras.nonempty = cnt != '0;

endmodule

// File: insn_predecode.sv
`timescale 1ns/10ps
`include "fetch_slice_config.svh"

module insn_predecode (
    input  logic [`FETCH_XLEN-1:0]  pc,
    input  rv_insn_pkg::insn_u      ir,
    input  logic [`FETCH_XLEN-1:0]  ras_top,
    output rv_insn_pkg::insn_kind_t kind,
    output logic [`FETCH_XLEN-1:0]  target,
    output logic [`FETCH_XLEN-1:0]  fallthrough
);
    import rv_insn_pkg::*;

    localparam int XLEN = `FETCH_XLEN;

    logic            is_rvc;
    logic [XLEN-1:0] imm;   // sign-extended offset

    always_comb begin
        is_rvc = ir.c.quadrant != Q_FULL;
        kind   = '0;
        imm    = '0;
        if (!is_rvc) begin
            case (ir.f.opcode)
                OPC_BRANCH: begin
                    kind.branch = 1'b1;
                    imm = XLEN'($signed({ir.f.funct7[6], ir.f.rd[0], ir.f.funct7[5:0],
                                         ir.f.rd[4:1], 1'b0}));
                end
                OPC_JAL: begin
                    kind.jal = 1'b1;
                    imm = XLEN'($signed({ir.f.funct7[6], ir.f.rs1, ir.f.funct3, ir.f.rs2[0],
                                         ir.f.funct7[5:0], ir.f.rs2[4:1], 1'b0}));
                end
                OPC_JALR: begin
                    kind.jalr = 1'b1;
                    imm = XLEN'($signed({ir.f.funct7, ir.f.rs2}));
                end
                default: ;
            endcase
            // same link reg on both sides counts as a call only
            kind.call = (kind.jal | kind.jalr) & is_link(ir.f.rd);
            kind.ret  = kind.jalr & is_link(ir.f.rs1) & (ir.f.rs1 != ir.f.rd);
        end else if (ir.c.quadrant == C_Q1 && ir.c.funct3 == C_F3_J) begin
            kind.jal = 1'b1;   // c.j
            imm = XLEN'($signed({ir.c.op12, ir.c.rs1[1], ir.c.rs1[3:2], ir.c.rs2[4],
                                 ir.c.rs1[0], ir.c.rs2[0], ir.c.rs1[4], ir.c.rs2[3:1],
                                 1'b0}));
        end else if (ir.c.quadrant == C_Q1 &&
                     (ir.c.funct3 == C_F3_BEQZ || ir.c.funct3 == C_F3_BNEZ)) begin
            kind.branch = 1'b1;
            imm = XLEN'($signed({ir.c.op12, ir.c.rs2[4:3], ir.c.rs2[0], ir.c.rs1[4:3],
                                 ir.c.rs2[2:1], 1'b0}));
        end else if (ir.c.quadrant == C_Q2 && ir.c.funct3 == C_F3_JR &&
                     ir.c.rs2 == 5'd0 && ir.c.rs1 != 5'd0) begin
            kind.jalr = 1'b1;          // c.jr / c.jalr
            kind.call = ir.c.op12;     // c.jalr links to ra
            kind.ret  = (ir.c.rs1 == 5'd1 && !ir.c.op12) || ir.c.rs1 == 5'd5;
        end
    end

    // jalr targets come from the stack, the register file is not visible here
    assign target      = (kind.jalr ? ras_top : pc) + imm;
    assign fallthrough = pc + (is_rvc ? XLEN'(2) : XLEN'(4));

endmodule

// File: fetch_intf.sv
`timescale 1ns/10ps
`include "fetch_slice_config.svh"

interface fq_enq_if;
    logic [$clog2(`FETCH_BLOCK_HW+1)-1:0]            count;  // slots written this cycle
    fetch_pkg::fetch_entry_t [`FETCH_BLOCK_HW-1:0] slot;
    logic [$clog2(`FETCH_FQ_DEPTH):0]              free;   // from the queue

    modport source (output count, slot, input free);
    modport sink   (input count, slot, output free);
endinterface

interface ras_if;
    logic                   push;
    logic                   pop;
    logic [`FETCH_XLEN-1:0] push_addr;
    logic [`FETCH_XLEN-1:0] top;
    logic                   nonempty;

    modport client (output push, pop, push_addr, input top, nonempty);
    modport stack  (input push, pop, push_addr, output top, nonempty);
endinterface

// File: fetch_pkg.sv
`include "fetch_slice_config.svh"

package fetch_pkg;

    typedef logic [`FETCH_XLEN-1:0] addr_t;

    typedef struct packed {
        addr_t                   pc;
        rv_insn_pkg::insn_u      ir;
        addr_t                   pnpc;  // predicted next pc
        rv_insn_pkg::insn_kind_t kind;
    } fetch_entry_t;

    typedef struct packed {
        logic  taken;   // for the insn ending on the last half-word
        addr_t target;
    } block_pred_t;

endpackage

// File: rv_insn_pkg.sv
package rv_insn_pkg;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [1:0] Q_FULL     = 2'b11;   // low bits of a 32-bit encoding
    localparam logic [1:0] C_Q1       = 2'b01;
    localparam logic [1:0] C_Q2       = 2'b10;
    localparam logic [2:0] C_F3_J     = 3'b101;  // c.j, quadrant 1
    localparam logic [2:0] C_F3_BEQZ  = 3'b110;
    localparam logic [2:0] C_F3_BNEZ  = 3'b111;
    localparam logic [2:0] C_F3_JR    = 3'b100;  // c.jr / c.jalr, quadrant 2

    typedef struct packed {
        logic [6:0] funct7;    // also upper immediate bits
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } insn_full_t;

    typedef struct packed {
        logic [15:0] next_hw;  // following half-word, not part of the insn
        logic [2:0]  funct3;
        logic        op12;
        logic [4:0]  rs1;      // rd/rs1 slot
        logic [4:0]  rs2;
        logic [1:0]  quadrant;
    } insn_rvc_t;

    // one fetched word, read either as a 32-bit or a compressed encoding
    typedef union packed {
        insn_full_t f;
        insn_rvc_t  c;
    } insn_u;

    typedef struct packed {
        logic branch;
        logic jal;
        logic jalr;
        logic call;
        logic ret;
    } insn_kind_t;

    function automatic logic is_link(input logic [4:0] r);
        return r == 5'd1 || r == 5'd5;  // ra or t0
    endfunction

endpackage

// File: fetch_slice_config.svh
`ifndef FETCH_SLICE_CONFIG_SVH
`define FETCH_SLICE_CONFIG_SVH

`define FETCH_XLEN      64  // virtual address width
`define FETCH_BLOCK_HW  4   // half-words per fetch block
`define FETCH_FQ_DEPTH  16  // fetch queue entries
`define FETCH_DEQ_WIDTH 2   // decode lanes
`define FETCH_RAS_DEPTH 8   // return stack entries

`endif
